// File: src/core_pkg.sv
// Core-wide widths and memory exception codes
// Shared by the fetch front end, its memory model and the checker
package core_pkg;

  // ----------------------------------------
  // Data path widths
  // ----------------------------------------

  // Address and register width
  localparam int unsigned XLEN = 32;

  // Uncompressed instruction width
  localparam int unsigned ILEN = 32;

  // ----------------------------------------
  // Exceptions
  // ----------------------------------------

  // Memory exception codes
  // Numbering follows the mcause encoding
  typedef enum logic [3:0] {
    E_I_ADDR_MISALIGNED = 4'h0,
    E_I_ACCESS_FAULT    = 4'h1
  } except_code_t;

endpackage

// File: src/fetch_pkg.sv
// Fetch front end constants and the records passed between its stages
// Request records flow toward memory, answer records toward issue
package fetch_pkg;

  // ----------------------------------------
  // Constants
  // ----------------------------------------

  // First fetch address out of reset
  localparam logic [core_pkg::XLEN-1:0] BOOT_PC = 32'h0000_1000;

  // PC FIFO depth, also the cap on requests in flight
  localparam int unsigned FETCH_FIFO_DEPTH = 2;

  // Sequential PC step
  localparam logic [core_pkg::XLEN-1:0] ILEN_BYTES = 32'd4;

  // ----------------------------------------
  // Records
  // ----------------------------------------

  // Prediction record, PC only
  typedef struct packed {
    logic [core_pkg::XLEN-1:0] pc;
  } fetch_req_t;

  // Fetched word paired with its PC
  typedef struct packed {
    logic [core_pkg::ILEN-1:0] instr;
    logic [core_pkg::XLEN-1:0] pc;
    logic                      except_raised;
    core_pkg::except_code_t    except_code;
  } fetch_ans_t;

endpackage

// File: src/spill_cell_flush.sv
// Two-entry elastic pipeline register with valid/ready on both sides
// ready_o comes straight from a flop, so no path crosses the cell
`timescale 1ns/1ps

module spill_cell_flush #(
  parameter type DATA_T = logic [31:0]
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  flush_i,
  input  logic  valid_i,
  output logic  ready_o,
  output logic  valid_o,
  input  logic  ready_i,
  input  DATA_T data_i,
  output DATA_T data_o
);

  // Main entry drives the outputs, spill entry catches the overflow
  logic  main_valid_q, spill_valid_q;
  DATA_T main_data_q, spill_data_q;
  logic  in_acc, main_free;

  assign in_acc    = valid_i & ready_o;
  // Main entry may load when empty or when being consumed
  assign main_free = ~main_valid_q | ready_i;

  // ----------------------------------------
  // Occupancy
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      main_valid_q  <= 1'b0;
      spill_valid_q <= 1'b0;
    end else if (main_free) begin
      // Spill entry drains first to keep order
      if (spill_valid_q) begin
        main_valid_q  <= 1'b1;
        spill_valid_q <= 1'b0;
      end else begin
        main_valid_q <= in_acc;
      end
    end else if (in_acc) begin
      // Output stalled, park the new item
      spill_valid_q <= 1'b1;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (main_free) begin
      main_data_q <= spill_valid_q ? spill_data_q : data_i;
    end
    if (!main_free && in_acc) begin
      spill_data_q <= data_i;
    end
  end

  assign ready_o = ~spill_valid_q;
  assign valid_o = main_valid_q;
  assign data_o  = main_data_q;

  // Stalled output keeps its item until taken
  a_hold_on_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && !ready_i && !flush_i |=> valid_o && $stable(data_o))
    else $error("spill cell changed a stalled output");

endmodule

// File: src/fifo_nohs.sv
// Small circular FIFO without handshake
// The user must not push when full nor pop when empty
`timescale 1ns/1ps

module fifo_nohs #(
  parameter type         DATA_T = logic [31:0],
  parameter int unsigned DEPTH  = 2
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  flush_i,
  input  logic  push_i,
  input  logic  pop_i,
  input  DATA_T data_i,
  output DATA_T data_o,
  output logic  full_o
);

  // Pointer stays one bit wide for a single entry
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  DATA_T            mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             empty;

  // ----------------------------------------
  // Pointers and count
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Oldest entry always visible
  assign data_o = mem_q[rd_ptr_q];
  assign full_o = (cnt_q == CNT_W'(DEPTH));
  assign empty  = (cnt_q == '0);

  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> !full_o || pop_i)
    else $error("push into a full FIFO");
  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> !empty)
    else $error("pop from an empty FIFO");

endmodule

// File: src/pc_gen.sv
// Sequential program counter for the fetch front end
// Steps one instruction per accepted request, loads targets on flush
`timescale 1ns/1ps

module pc_gen (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      flush_i,
  input  logic [core_pkg::XLEN-1:0] redirect_pc_i,
  input  logic                      en_i,
  output logic                      valid_o,
  input  logic                      ready_i,
  output fetch_pkg::fetch_req_t     req_o
);

  import core_pkg::*;
  import fetch_pkg::*;

  logic [XLEN-1:0] pc_q;

  // ----------------------------------------
  // PC register
  // ----------------------------------------
  // Redirect beats the sequential step
  // The step only happens on a request handshake
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q <= BOOT_PC;
    end else if (flush_i) begin
      pc_q <= redirect_pc_i;
    end else if (valid_o && ready_i) begin
      pc_q <= pc_q + ILEN_BYTES;
    end
  end

  // Controller decides whether requests go out
  assign valid_o  = en_i;
  assign req_o.pc = pc_q;

endmodule

// File: src/fetch_ctrl.sv
// Fetch control FSM
// Tracks memory requests in flight and discards stale answers after a redirect
`timescale 1ns/1ps

module fetch_ctrl (
  input  logic clk_i,
  input  logic rst_i,
  input  logic redirect_i,
  input  logic req_acc_i,
  input  logic ans_acc_i,
  output logic flush_o,
  output logic drop_o,
  output logic fetch_en_o
);

  import fetch_pkg::*;

  localparam int unsigned CNT_W = $clog2(FETCH_FIFO_DEPTH + 1);

  typedef enum logic {
    FETCH,
    DRAIN
  } state_t;

  state_t           state_q, state_d;
  logic [CNT_W-1:0] cnt_q, cnt_d;

  // ----------------------------------------
  // In-flight counter
  // ----------------------------------------
  // Requests accepted by memory minus answers accepted from it
  // Keeps counting through a redirect, so it doubles as the drain count
  always_comb begin
    case ({req_acc_i, ans_acc_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH: begin
        // Old answers still due, go discard them
        if (redirect_i && cnt_d != '0) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        if (cnt_d == '0) begin
          state_d = FETCH;
        end
      end
      default: state_d = FETCH;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= FETCH;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Outputs
  assign flush_o    = redirect_i;
  assign drop_o     = (state_q == DRAIN);
  // PC generator stays idle while draining
  assign fetch_en_o = (state_q == FETCH);

  a_cnt_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    cnt_q <= CNT_W'(FETCH_FIFO_DEPTH))
    else $error("more memory requests in flight than the PC FIFO holds");
  // Memory never answers a request it was not given
  a_no_orphan_ans: assert property (@(posedge clk_i) disable iff (rst_i)
    ans_acc_i |-> cnt_q != '0)
    else $error("memory answer with no request in flight");

endmodule

// File: src/fetch_mem_if.sv
// Fetch memory interface
// Request register toward memory, PC FIFO while memory works, answer
// register toward issue. Memory must answer in order
`timescale 1ns/1ps

module fetch_mem_if (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      flush_i,
  input  logic                      drop_i,

  // Fetch side
  input  logic                      fetch_valid_i,
  output logic                      fetch_ready_o,
  input  fetch_pkg::fetch_req_t     fetch_req_i,

  // Issue side
  output logic                      issue_valid_o,
  input  logic                      issue_ready_i,
  output fetch_pkg::fetch_ans_t     issue_ans_o,

  // Memory side
  output logic                      instr_valid_o,
  input  logic                      instr_ready_i,
  output logic [core_pkg::XLEN-1:0] instr_addr_o,
  input  logic                      instr_valid_i,
  output logic                      instr_ready_o,
  input  logic [core_pkg::ILEN-1:0] instr_rdata_i,
  input  logic                      instr_except_raised_i,
  input  core_pkg::except_code_t    instr_except_code_i,

  // Handshake pulses to the controller
  output logic                      req_acc_o,
  output logic                      ans_acc_o
);

  import fetch_pkg::*;

  fetch_req_t req_reg_out, fifo_out;
  fetch_ans_t ans_reg_in;
  logic       req_reg_valid, req_reg_ready;
  logic       fifo_push, fifo_pop, fifo_full;
  logic       ans_reg_valid, ans_reg_ready;

  // ----------------------------------------
  // Request register
  // ----------------------------------------
  spill_cell_flush #(
    .DATA_T(fetch_req_t)
  ) u_req_reg (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .flush_i(flush_i),
    .valid_i(fetch_valid_i),
    .ready_o(fetch_ready_o),
    .valid_o(req_reg_valid),
    .ready_i(req_reg_ready),
    .data_i (fetch_req_i),
    .data_o (req_reg_out)
  );

  // No new request unless its PC has a FIFO slot
  assign instr_valid_o = req_reg_valid & ~fifo_full;
  assign req_reg_ready = instr_ready_i & ~fifo_full;
  assign instr_addr_o  = req_reg_out.pc;
  assign req_acc_o     = instr_valid_o & instr_ready_i;

  // ----------------------------------------
  // PC FIFO
  // ----------------------------------------
  // Popped only by answers that are kept
  assign fifo_push = req_acc_o;
  assign fifo_pop  = instr_valid_i & ans_reg_ready & ~drop_i;

  fifo_nohs #(
    .DATA_T(fetch_req_t),
    .DEPTH (FETCH_FIFO_DEPTH)
  ) u_pc_fifo (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .flush_i(flush_i),
    .push_i (fifo_push),
    .pop_i  (fifo_pop),
    .data_i (req_reg_out),
    .data_o (fifo_out),
    .full_o (fifo_full)
  );

  // ----------------------------------------
  // Answer register
  // ----------------------------------------
  assign ans_reg_in.instr         = instr_rdata_i;
  assign ans_reg_in.pc            = fifo_out.pc;
  assign ans_reg_in.except_raised = instr_except_raised_i;
  assign ans_reg_in.except_code   = instr_except_code_i;

  // Stale answers are swallowed while draining
  assign ans_reg_valid = instr_valid_i & ~drop_i;

  spill_cell_flush #(
    .DATA_T(fetch_ans_t)
  ) u_ans_reg (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .flush_i(flush_i),
    .valid_i(ans_reg_valid),
    .ready_o(ans_reg_ready),
    .valid_o(issue_valid_o),
    .ready_i(issue_ready_i),
    .data_i (ans_reg_in),
    .data_o (issue_ans_o)
  );

  assign instr_ready_o = drop_i | ans_reg_ready;
  assign ans_acc_o     = instr_valid_i & instr_ready_o;

endmodule

// File: src/fetch_unit.sv
// Instruction fetch front end top level
// PC generator and controller in front of the memory interface
`timescale 1ns/1ps

module fetch_unit (
  input  logic                      clk_i,
  input  logic                      rst_i,

  // Back end redirect
  input  logic                      redirect_i,
  input  logic [core_pkg::XLEN-1:0] redirect_pc_i,

  // Issue stage
  output logic                      issue_valid_o,
  input  logic                      issue_ready_i,
  output fetch_pkg::fetch_ans_t     issue_ans_o,

  // Instruction memory
  output logic                      instr_valid_o,
  input  logic                      instr_ready_i,
  output logic [core_pkg::XLEN-1:0] instr_addr_o,
  input  logic                      instr_valid_i,
  output logic                      instr_ready_o,
  input  logic [core_pkg::ILEN-1:0] instr_rdata_i,
  input  logic                      instr_except_raised_i,
  input  core_pkg::except_code_t    instr_except_code_i
);

  import fetch_pkg::*;

  // ----------------------------------------
  // Internal wires
  // ----------------------------------------
  fetch_req_t pc_req;
  logic       pc_valid, pc_ready;
  logic       flush, drop, fetch_en;
  logic       req_acc, ans_acc;

  pc_gen u_pc_gen (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .flush_i      (flush),
    .redirect_pc_i(redirect_pc_i),
    .en_i         (fetch_en),
    .valid_o      (pc_valid),
    .ready_i      (pc_ready),
    .req_o        (pc_req)
  );

  fetch_ctrl u_fetch_ctrl (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .redirect_i(redirect_i),
    .req_acc_i (req_acc),
    .ans_acc_i (ans_acc),
    .flush_o   (flush),
    .drop_o    (drop),
    .fetch_en_o(fetch_en)
  );

  fetch_mem_if u_fetch_mem_if (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .flush_i              (flush),
    .drop_i               (drop),
    .fetch_valid_i        (pc_valid),
    .fetch_ready_o        (pc_ready),
    .fetch_req_i          (pc_req),
    .issue_valid_o        (issue_valid_o),
    .issue_ready_i        (issue_ready_i),
    .issue_ans_o          (issue_ans_o),
    .instr_valid_o        (instr_valid_o),
    .instr_ready_i        (instr_ready_i),
    .instr_addr_o         (instr_addr_o),
    .instr_valid_i        (instr_valid_i),
    .instr_ready_o        (instr_ready_o),
    .instr_rdata_i        (instr_rdata_i),
    .instr_except_raised_i(instr_except_raised_i),
    .instr_except_code_i  (instr_except_code_i),
    .req_acc_o            (req_acc),
    .ans_acc_o            (ans_acc)
  );

endmodule

// File: test/fetch_checker.sv
// Issue stream checker for the fetch front end
// Predicts every issued record from the PC rules and the memory map,
// and flags valid outputs during reset and a wrong boot request
`timescale 1ns/1ps

module fetch_checker (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      redirect_i,
  input  logic [core_pkg::XLEN-1:0] redirect_pc_i,
  input  logic                      issue_valid_i,
  input  logic                      issue_ready_i,
  input  fetch_pkg::fetch_ans_t     issue_ans_i,
  input  logic                      mem_req_valid_i,
  input  logic [core_pkg::XLEN-1:0] mem_req_addr_i,
  output int unsigned               err_cnt_o,
  output int unsigned               issue_cnt_o,
  output int unsigned               fault_cnt_o
);

  import core_pkg::*;
  import fetch_pkg::*;

  logic [XLEN-1:0] exp_pc_q;
  logic [XLEN-1:0] next_pc;
  logic            in_rst_q    = 1'b0;
  logic            boot_seen_q = 1'b0;
  fetch_ans_t      exp_ans;
  int unsigned     bad;
  int unsigned     err_cnt     = 0;
  int unsigned     issue_cnt   = 0;
  int unsigned     fault_cnt   = 0;

  assign err_cnt_o   = err_cnt;
  assign issue_cnt_o = issue_cnt;
  assign fault_cnt_o = fault_cnt;

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  // Fault window 0x0000_F000 to 0x0000_FFFF, zero word there
  function automatic fetch_ans_t expected_answer(input logic [XLEN-1:0] pc);
    fetch_ans_t ans;
    ans.pc            = pc;
    ans.except_raised = (pc[31:12] == 20'h0000f);
    ans.except_code   = ans.except_raised ? E_I_ACCESS_FAULT : E_I_ADDR_MISALIGNED;
    ans.instr         = ans.except_raised ? '0 : (pc ^ {pc[15:0], pc[31:16]}) * 32'h9e37_79b1;
    return ans;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("MISMATCH %s: expected %h, actual %h", name, exp_v, act_v);
  endtask

  // ----------------------------------------
  // Compare process
  // ----------------------------------------
  always @(posedge clk_i) begin
    bad     = 0;
    next_pc = exp_pc_q;
    in_rst_q <= rst_i;
    if (rst_i) begin
      // Skip the first edge, flops are not reset before it
      if (in_rst_q && (mem_req_valid_i || issue_valid_i)) begin
        bad++;
        $display("ERROR: memory or issue valid went high during reset");
      end
      next_pc = BOOT_PC;
      boot_seen_q <= 1'b0;
    end else begin
      if (mem_req_valid_i && !boot_seen_q) begin
        boot_seen_q <= 1'b1;
        if (mem_req_addr_i !== BOOT_PC) begin
          bad++;
          report_mismatch("boot_request", BOOT_PC, mem_req_addr_i);
        end
      end
      if (issue_valid_i && issue_ready_i) begin
        exp_ans = expected_answer(exp_pc_q);
        if (issue_ans_i.pc !== exp_ans.pc) begin
          bad++;
          report_mismatch("pc_sequence", exp_ans.pc, issue_ans_i.pc);
        end
        if (issue_ans_i.instr !== exp_ans.instr) begin
          bad++;
          report_mismatch("instr_pairing", exp_ans.instr, issue_ans_i.instr);
        end
        if (issue_ans_i.except_raised !== exp_ans.except_raised) begin
          bad++;
          report_mismatch("except_flag", 32'(exp_ans.except_raised),
                          32'(issue_ans_i.except_raised));
        end
        // Code only means something when the flag is set
        if (exp_ans.except_raised && issue_ans_i.except_code !== exp_ans.except_code) begin
          bad++;
          report_mismatch("except_code", 32'(exp_ans.except_code),
                          32'(issue_ans_i.except_code));
        end
        if (exp_ans.except_raised) begin
          fault_cnt <= fault_cnt + 1;
        end
        issue_cnt <= issue_cnt + 1;
        next_pc = exp_pc_q + ILEN_BYTES;
      end
      // Redirect lands after the issue of the same cycle
      if (redirect_i) begin
        next_pc = redirect_pc_i;
      end
    end
    exp_pc_q <= next_pc;
    err_cnt  <= err_cnt + bad;
  end

endmodule

// File: test/tb_fetch_unit.sv
// Testbench top for the fetch front end
// Models an in-order instruction memory, drives issue back-pressure and
// redirects over three phases, then prints the verdict from all counters
`timescale 1ns/1ps

module tb_fetch_unit;

  import core_pkg::*;
  import fetch_pkg::*;

  localparam logic [31:0] SEED     = 32'hc071_383f;
  // Redirect target just below the end of the fault window
  localparam logic [31:0] FAULT_PC = 32'h0000_fff0;

  typedef enum logic [1:0] {
    PH_RESET,
    PH_SEQ,
    PH_FAULT,
    PH_RAND
  } phase_t;

  // DUT inputs, all start idle
  logic            clk_i                 = 1'b0;
  logic            rst_i                 = 1'b1;
  logic            redirect_i            = 1'b0;
  logic [XLEN-1:0] redirect_pc_i         = '0;
  logic            issue_ready_i         = 1'b0;
  logic            instr_ready_i         = 1'b0;
  logic            instr_valid_i         = 1'b0;
  logic [ILEN-1:0] instr_rdata_i         = '0;
  logic            instr_except_raised_i = 1'b0;
  except_code_t    instr_except_code_i   = E_I_ADDR_MISALIGNED;

  // DUT outputs
  logic            issue_valid_o, instr_valid_o, instr_ready_o;
  fetch_ans_t      issue_ans_o;
  logic [XLEN-1:0] instr_addr_o;

  integer          seed       = SEED;
  logic [31:0]     rnd, rnd_pc;
  logic            busy;
  logic            fault_sent = 1'b0;
  phase_t          phase      = PH_RESET;
  int unsigned     rst_cnt    = 0;
  int unsigned     mem_errs   = 0;
  int unsigned     run_errs   = 0;
  int unsigned     err_cnt, issue_cnt, fault_cnt;
  // Addresses taken by memory and not yet answered, oldest first
  logic [XLEN-1:0] pend_q [$];

  always #5 clk_i = ~clk_i;

  // Reset seen by the DUT on five rising edges
  always @(posedge clk_i) begin
    if (rst_cnt < 5) begin
      rst_cnt <= rst_cnt + 1;
    end
    rst_i <= (rst_cnt < 4);
  end

  fetch_unit fetch_unit_i (.*);

  fetch_checker u_checker (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .redirect_i     (redirect_i),
    .redirect_pc_i  (redirect_pc_i),
    .issue_valid_i  (issue_valid_o),
    .issue_ready_i  (issue_ready_i),
    .issue_ans_i    (issue_ans_o),
    .mem_req_valid_i(instr_valid_o),
    .mem_req_addr_i (instr_addr_o),
    .err_cnt_o      (err_cnt),
    .issue_cnt_o    (issue_cnt),
    .fault_cnt_o    (fault_cnt)
  );

  // ----------------------------------------
  // Memory contents
  // ----------------------------------------
  function automatic logic in_fault_range(input logic [XLEN-1:0] addr);
    return addr[31:12] == 20'h0000f;
  endfunction

  // Faulting fetches return a zero word
  function automatic logic [ILEN-1:0] mem_word(input logic [XLEN-1:0] addr);
    return in_fault_range(addr) ? '0 : (addr ^ {addr[15:0], addr[31:16]}) * 32'h9e37_79b1;
  endfunction

  // ----------------------------------------
  // Memory responder and stimulus
  // ----------------------------------------
  always @(posedge clk_i) begin
    if (rst_i) begin
      pend_q.delete();
      instr_valid_i <= 1'b0;
      instr_ready_i <= 1'b0;
      issue_ready_i <= 1'b0;
      redirect_i    <= 1'b0;
    end else begin
      rnd    = $random(seed);
      rnd_pc = $random(seed);
      busy   = instr_valid_i;
      // Answer taken on this edge
      if (instr_valid_i && instr_ready_o) begin
        void'(pend_q.pop_front());
        busy = 1'b0;
      end
      if (instr_valid_o && instr_ready_i) begin
        pend_q.push_back(instr_addr_o);
      end
      if (pend_q.size() > FETCH_FIFO_DEPTH) begin
        mem_errs++;
        $display("ERROR: memory holds %0d unanswered requests, limit is %0d",
                 pend_q.size(), FETCH_FIFO_DEPTH);
      end
      if (phase == PH_RAND) begin
        issue_ready_i <= (rnd[1:0] != 2'b00);
        instr_ready_i <= (rnd[3:2] != 2'b00);
        // Roughly one redirect in 32 cycles, anywhere in the low 64 KiB
        redirect_i    <= (rnd[9:5] == 5'd0);
        redirect_pc_i <= {16'h0000, rnd_pc[15:2], 2'b00};
      end else begin
        issue_ready_i <= 1'b1;
        instr_ready_i <= 1'b1;
        redirect_i    <= 1'b0;
        // One jump into the fault window
        if (phase == PH_FAULT && !fault_sent) begin
          redirect_i    <= 1'b1;
          redirect_pc_i <= FAULT_PC;
          fault_sent    = 1'b1;
        end
      end
      // A presented answer holds until taken
      if (!busy) begin
        if (pend_q.size() != 0 && (phase != PH_RAND || rnd[4])) begin
          instr_valid_i         <= 1'b1;
          instr_rdata_i         <= mem_word(pend_q[0]);
          instr_except_raised_i <= in_fault_range(pend_q[0]);
          instr_except_code_i   <= in_fault_range(pend_q[0]) ? E_I_ACCESS_FAULT
                                                             : E_I_ADDR_MISALIGNED;
        end else begin
          instr_valid_i <= 1'b0;
        end
      end
    end
  end

  // ----------------------------------------
  // Run control
  // ----------------------------------------
  task automatic wait_reset_release(input int unsigned limit);
    int unsigned cycles;
    cycles = 0;
    while (rst_i && cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    if (rst_i) begin
      run_errs++;
      $display("ERROR: reset still asserted after %0d cycles", cycles);
    end
  endtask

  task automatic wait_issues(input int unsigned target, input int unsigned limit,
                             input string what);
    int unsigned cycles;
    cycles = 0;
    while (issue_cnt < target && cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    if (issue_cnt < target) begin
      run_errs++;
      $display("ERROR: %s timed out with %0d of %0d instructions issued after %0d cycles",
               what, issue_cnt, target, cycles);
    end
  endtask

  initial begin
    wait_reset_release(20);
    // Phases change on the falling edge, clear of the stimulus edge
    @(negedge clk_i);
    phase = PH_SEQ;
    wait_issues(20, 500, "sequential fetch");
    if (run_errs == 0) begin
      @(negedge clk_i);
      phase = PH_FAULT;
      wait_issues(issue_cnt + 12, 500, "fault window fetch");
    end
    if (run_errs == 0) begin
      @(negedge clk_i);
      phase = PH_RAND;
      wait_issues(issue_cnt + 400, 20000, "random back-pressure");
    end
    @(negedge clk_i);
    if (fault_cnt == 0) begin
      run_errs++;
      $display("ERROR: no fetch in the fault window was ever issued");
    end
    $display("issued %0d, mismatches %0d, memory errors %0d, run errors %0d",
             issue_cnt, err_cnt, mem_errs, run_errs);
    if (err_cnt == 0 && mem_errs == 0 && run_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: src.f
src/core_pkg.sv
src/fetch_pkg.sv
src/spill_cell_flush.sv
src/fifo_nohs.sv
src/pc_gen.sv
src/fetch_ctrl.sv
src/fetch_mem_if.sv
src/fetch_unit.sv
test/fetch_checker.sv
test/tb_fetch_unit.sv

// File: Makefile
# Verilator build and run of the fetch front end testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_fetch_unit
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := >>> PASS
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qxF -- '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
